// ==== design/arithPkg.sv ====
`default_nettype none

package arithPkg;

	// datapath width of the adder
	localparam int dataW = 16;

	// carry network form, 0 serial, 1 Brent-Kung, 2 Sklansky
	localparam int prefixSpeed = 2;

	typedef enum logic [1:0] {
		opAdd  = 2'd0,
		opSub  = 2'd1,
		opAddC = 2'd2, // add with carry-in
		opSubC = 2'd3  // cin 1 means no borrow
	} arithOp_t;

	// status bits returned with every result
	typedef struct packed {
		logic carry;
		logic overflow;
		logic zero;
		logic negative;
	} arithFlags_t;

endpackage

`default_nettype wire

// ==== design/busPkg.sv ====
`default_nettype none

package busPkg;

	import arithPkg::*;

	// one operation as presented on the req/ack port
	typedef struct packed {
		arithOp_t         op;
		logic [dataW-1:0] a;
		logic [dataW-1:0] b;
		logic             cin; // used by opAddC and opSubC only
	} arithReq_t;

	// result word plus status
	typedef struct packed {
		logic [dataW-1:0] sum;
		arithFlags_t      flags;
	} arithRsp_t;

endpackage

`default_nettype wire

// ==== design/PrefixAndOr.sv ====
`timescale 1ns/100ps
`default_nettype none

module PrefixAndOr #(
	parameter int width = 8, // word width
	parameter int speed = 2  // 0 serial, 1 Brent-Kung, 2 Sklansky
) (
	input  logic [width-1:0] GI, // bitwise generate
	input  logic [width-1:0] PI, // bitwise propagate
	output logic [width-1:0] GO, // group generate from bit 0
	output logic [width-1:0] PO  // group propagate from bit 0
);

	// tree depth
	localparam int m = $clog2(width);

	// last bit of the lower half-block that bit j joins at Sklansky level l
	function automatic int sklanskySrc(input int j, input int l);
		int base;
		base = (j >> (l - 1)) << (l - 1);
		return base - 1;
	endfunction

	if (speed == 0) begin : slowPrefix
		// ripple chain, one node per bit
		logic [width-1:0] gT, pT;

		always_comb begin
			gT = GI;
			pT = PI;
			for (int j = 1; j < width; j++) begin
				gT[j] = GI[j] | (PI[j] & gT[j-1]);
				pT[j] = PI[j] & pT[j-1];
			end
		end

		assign GO = gT;
		assign PO = pT;

	end else if (speed == 1) begin : mediumPrefix
		// up-sweep builds power-of-two groups, down-sweep fills the gaps
		logic [width-1:0] gT, pT;

		always_comb begin
			gT = GI;
			pT = PI;
			// up-sweep
			for (int l = 1; l <= m; l++) begin
				for (int j = 0; j < width; j++) begin
					if (((j + 1) & ((1 << l) - 1)) == 0) begin
						gT[j] = gT[j] | (pT[j] & gT[j - (1 << (l - 1))]);
						pT[j] = pT[j] & pT[j - (1 << (l - 1))];
					end
				end
			end
			// down-sweep, source nodes are already complete here
			for (int l = m - 1; l >= 1; l--) begin
				for (int j = 0; j < width; j++) begin
					if ((((j + 1) & ((1 << l) - 1)) == (1 << (l - 1))) &&
					    (j >= (1 << l))) begin
						gT[j] = gT[j] | (pT[j] & gT[j - (1 << (l - 1))]);
						pT[j] = pT[j] & pT[j - (1 << (l - 1))];
					end
				end
			end
		end

		assign GO = gT;
		assign PO = pT;

	end else begin : fastPrefix
		// Sklansky, upper half of each block joins the top of the lower half
		logic [width-1:0] gT, pT;

		always_comb begin
			gT = GI;
			pT = PI;
			for (int l = 1; l <= m; l++) begin
				for (int j = 0; j < width; j++) begin
					if (((j >> (l - 1)) & 1) == 1) begin
						// source bit is never written at the same level
						gT[j] = gT[j] | (pT[j] & gT[sklanskySrc(j, l)]);
						pT[j] = pT[j] & pT[sklanskySrc(j, l)];
					end
				end
			end
		end

		assign GO = gT;
		assign PO = pT;
	end

endmodule

`default_nettype wire

// ==== design/PrefixAndOrCfast.sv ====
`timescale 1ns/100ps
`default_nettype none

module PrefixAndOrCfast #(
	parameter int width = 8, // word width
	parameter int speed = 2  // prefix form, see PrefixAndOr
) (
	input  logic [width-1:0] GI,
	input  logic [width-1:0] PI, // bitwise gen./prop.
	input  logic             CI, // carry in
	output logic [width-1:0] GO, // group generate incl. carry-in
	output logic [width-1:0] PO  // group propagate
);

	logic [width-1:0] gT, pT; // tree outputs before carry-in

	PrefixAndOr #(
		.width(width),
		.speed(speed)
	) prefix (
		.GI(GI),
		.PI(PI),
		.GO(gT),
		.PO(pT)
	);

	// one extra AND-OR level, carry-in enters only here
	assign GO = gT | (pT & {width{CI}});
	assign PO = pT;

endmodule

`default_nettype wire

// ==== design/AddSubCore.sv ====
`timescale 1ns/100ps
`default_nettype none

module AddSubCore
	import arithPkg::*;
	import busPkg::*;
(
	input  arithReq_t req,
	output arithRsp_t rsp
);

	logic             isSub;
	logic             carryIn;
	logic [dataW-1:0] bOp;    // b after conditioning
	logic [dataW-1:0] gen;    // a & b
	logic [dataW-1:0] prop;   // a ^ b
	logic [dataW-1:0] grpGen; // group generate from bit 0, carry-in folded in
	logic [dataW-1:0] carry;  // carry into each bit
	logic [dataW-1:0] sum;

	// operation decode
	always_comb begin
		isSub = (req.op == opSub) || (req.op == opSubC);
		case (req.op)
			opAdd:         carryIn = 1'b0;
			opSub:         carryIn = 1'b1; // two's complement +1
			opAddC, opSubC: carryIn = req.cin;
			default:       carryIn = 1'b0;
		endcase
	end

	assign bOp  = isSub ? ~req.b : req.b;
	assign gen  = req.a & bOp;
	assign prop = req.a ^ bOp;

	PrefixAndOrCfast #(
		.width(dataW),
		.speed(prefixSpeed)
	) carryNet (
		.GI(gen),
		.PI(prop),
		.CI(carryIn),
		.GO(grpGen),
		.PO()
	);

	// carry into bit i is the group generate of bit i-1
	assign carry = {grpGen[dataW-2:0], carryIn};
	assign sum   = prop ^ carry;

	always_comb begin
		rsp.sum            = sum;
		rsp.flags.carry    = grpGen[dataW-1];           // no borrow on subtract
		rsp.flags.overflow = carry[dataW-1] ^ grpGen[dataW-1];
		rsp.flags.zero     = (sum == '0);
		rsp.flags.negative = sum[dataW-1];
	end

endmodule

`default_nettype wire

// ==== design/ReqAckPort.sv ====
`timescale 1ns/100ps
`default_nettype none

module ReqAckPort
	import busPkg::*;
(
	input  logic      clk,
	input  logic      rstN,
	input  logic      req,
	input  arithReq_t reqData,
	output logic      ack,
	output arithRsp_t rspData,
	output arithReq_t opReq, // captured request to the core
	input  arithRsp_t opRsp  // core result, combinational
);

	typedef enum logic [1:0] {
		stIdle,
		stCompute,
		stHold
	} portState_t;

	portState_t state, stateNext;

	always_comb begin
		stateNext = state;
		case (state)
			stIdle: begin
				if (req) stateNext = stCompute;
			end
			stCompute: stateNext = stHold; // result registered on this edge
			stHold: begin
				if (!req) stateNext = stIdle; // wait for req to drop
			end
			default: stateNext = stIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) state <= stIdle;
		else state <= stateNext;
	end

	// operand capture
	always_ff @(posedge clk) begin
		if (state == stIdle && req) opReq <= reqData;
	end

	// result register, zero after reset
	always_ff @(posedge clk) begin
		if (!rstN) rspData <= '0;
		else if (state == stCompute) rspData <= opRsp;
	end

	assign ack = (state == stHold);

	// req must still be up on the edge that raises ack
	ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
		$rose(ack) |-> $past(req))
		else $error("ack rose after req had already dropped");

	rspStable: assert property (@(posedge clk) disable iff (!rstN)
		(ack && $past(ack)) |-> $stable(rspData))
		else $error("rspData changed while ack high");

	ackFallsAfterReq: assert property (@(posedge clk) disable iff (!rstN)
		$fell(ack) |-> !$past(req))
		else $error("ack fell while req still high");

endmodule

`default_nettype wire

// ==== design/ArithUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module ArithUnit
	import busPkg::*;
(
	input  logic      clk,
	input  logic      rstN,
	input  logic      req,
	input  arithReq_t reqData,
	output logic      ack,
	output arithRsp_t rspData
);

	arithReq_t opReq; // port to core
	arithRsp_t opRsp; // core to port

	// four-phase front end
	ReqAckPort port (
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.reqData(reqData),
		.ack(ack),
		.rspData(rspData),
		.opReq(opReq),
		.opRsp(opRsp)
	);

	// prefix adder, zero latency
	AddSubCore core (
		.req(opReq),
		.rsp(opRsp)
	);

endmodule

`default_nettype wire

// ==== test/tbArith.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbArith
	import arithPkg::*;
	import busPkg::*;
();

	localparam int resetCycles = 10;
	localparam int idleCycles  = 20; // req held low, no ack allowed
	localparam int nShake      = 4;
	localparam int nAdd        = 80;
	localparam int nSub        = 80;
	localparam int nCarryRand  = 64;
	localparam int nCarryDir   = 7;
	localparam int nEdge       = 8;
	localparam int txTotal     = nShake + nAdd + nSub + nCarryRand + nCarryDir + nEdge;
	localparam int txCycles    = 8;  // worst case transfer incl. slow req drop
	localparam int timeoutCycles = resetCycles + idleCycles + txTotal * txCycles + 100;

	logic      clk;
	logic      rstN;
	logic      req;
	arithReq_t reqData;
	logic      ack;
	arithRsp_t rspData;

	arithRsp_t expRsp; // model result for the request on the port
	int        seed;
	int        errCount;
	int        txCount;
	int        testsPassed;
	int        testsFailed;
	int        cycleCount;

	ArithUnit uut (
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.reqData(reqData),
		.ack(ack),
		.rspData(rspData)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// expected result from a plain wide addition
	function automatic arithRsp_t refModel(input arithReq_t r);
		logic [dataW:0]   wide;
		logic [dataW-1:0] bEff;
		logic             c0;
		arithRsp_t        m;
		bEff = (r.op == opSub || r.op == opSubC) ? ~r.b : r.b;
		if (r.op == opAdd) c0 = 1'b0;
		else if (r.op == opSub) c0 = 1'b1;
		else c0 = r.cin;
		wide = {1'b0, r.a} + {1'b0, bEff} + {{dataW{1'b0}}, c0};
		m.sum            = wide[dataW-1:0];
		m.flags.carry    = wide[dataW];
		// signed overflow, equal operand signs but a different result sign
		m.flags.overflow = (r.a[dataW-1] == bEff[dataW-1]) && (m.sum[dataW-1] != r.a[dataW-1]);
		m.flags.zero     = (m.sum == '0);
		m.flags.negative = m.sum[dataW-1];
		return m;
	endfunction

	function automatic logic [dataW-1:0] randWord();
		int r;
		r = $random(seed);
		return r[dataW-1:0];
	endfunction

	function automatic logic randBit();
		int r;
		r = $random(seed);
		return r[4];
	endfunction

	// one full four-phase cycle as the requester
	task automatic transfer(input arithOp_t op, input logic [dataW-1:0] a,
		input logic [dataW-1:0] b, input logic cin, input int holdCycles);
		@(negedge clk);
		reqData.op  = op;
		reqData.a   = a;
		reqData.b   = b;
		reqData.cin = cin;
		expRsp      = refModel(reqData);
		req         = 1'b1;
		do @(negedge clk); while (!ack);
		repeat (holdCycles) @(negedge clk); // slow requester keeps ack high
		req = 1'b0;
		do @(negedge clk); while (ack);
		txCount++;
	endtask

	task automatic reportTest(input string name, input int errStart, input int txStart);
		int errs;
		repeat (2) @(negedge clk); // let trailing checks settle
		errs = errCount - errStart;
		$display("test %-10s %0d transfers, %0d errors, %s", name, txCount - txStart, errs,
			(errs == 0) ? "ok" : "failed");
		if (errs == 0) testsPassed++;
		else testsFailed++;
	endtask

	task automatic testHandshake();
		int errStart;
		int txStart;
		errStart = errCount;
		txStart  = txCount;
		resetAck: assert (ack === 1'b0)
			else begin
				errCount++;
				$display("[ERROR] ack = %h after reset, expected 0", ack);
			end
		resetRsp: assert (rspData === '0)
			else begin
				errCount++;
				$display("[ERROR] rspData = %h after reset, expected %h", rspData, 20'h0);
			end
		repeat (idleCycles) @(negedge clk); // idle, ack must stay low
		for (int i = 0; i < nShake; i++) begin
			transfer(opAdd, randWord(), randWord(), 1'b0, i);
		end
		reportTest("handshake", errStart, txStart);
	endtask

	task automatic testAdd();
		int errStart;
		int txStart;
		errStart = errCount;
		txStart  = txCount;
		for (int i = 0; i < nAdd; i++) transfer(opAdd, randWord(), randWord(), randBit(), 0);
		reportTest("add", errStart, txStart);
	endtask

	task automatic testSub();
		int errStart;
		int txStart;
		errStart = errCount;
		txStart  = txCount;
		for (int i = 0; i < nSub; i++) transfer(opSub, randWord(), randWord(), randBit(), 0);
		reportTest("sub", errStart, txStart);
	endtask

	task automatic testCarryIn();
		int errStart;
		int txStart;
		errStart = errCount;
		txStart  = txCount;
		// long carry chains through a full propagate word
		transfer(opAddC, 16'hffff, 16'h0000, 1'b1, 0);
		transfer(opAddC, 16'hffff, 16'h0000, 1'b0, 0);
		transfer(opAddC, 16'haaaa, 16'h5555, 1'b1, 0);
		transfer(opAddC, 16'h7fff, 16'h0000, 1'b1, 0);
		transfer(opSubC, 16'h0005, 16'h0005, 1'b1, 0); // no borrow
		transfer(opSubC, 16'h0005, 16'h0005, 1'b0, 0); // borrow in
		transfer(opSubC, 16'h0000, 16'h0000, 1'b0, 0);
		for (int i = 0; i < nCarryRand; i++) begin
			transfer(randBit() ? opAddC : opSubC, randWord(), randWord(), randBit(), 0);
		end
		reportTest("carry-in", errStart, txStart);
	endtask

	task automatic testEdge();
		int errStart;
		int txStart;
		errStart = errCount;
		txStart  = txCount;
		transfer(opAdd, 16'h0000, 16'h0000, 1'b0, 0);
		transfer(opSub, 16'h8000, 16'h0001, 1'b0, 0); // most negative minus one
		transfer(opAdd, 16'h7fff, 16'h0001, 1'b0, 0); // most positive plus one
		transfer(opSub, 16'h1234, 16'h1234, 1'b0, 0);
		transfer(opAdd, 16'hffff, 16'h0001, 1'b0, 0);
		transfer(opAdd, 16'h8000, 16'h8000, 1'b0, 0);
		transfer(opSub, 16'h0000, 16'h0001, 1'b0, 0);
		transfer(opSub, 16'h7fff, 16'hffff, 1'b0, 0);
		reportTest("edge", errStart, txStart);
	endtask

	// result checks against the model
	sumMatches: assert property (@(posedge clk) disable iff (!rstN)
		ack |-> (rspData.sum == expRsp.sum))
		else begin
			errCount++;
			$display("[ERROR] rspData.sum = %h, expected %h (op %0d a %h b %h cin %h)",
				$sampled(rspData.sum), $sampled(expRsp.sum), $sampled(reqData.op),
				$sampled(reqData.a), $sampled(reqData.b), $sampled(reqData.cin));
		end

	flagsMatch: assert property (@(posedge clk) disable iff (!rstN)
		ack |-> (rspData.flags == expRsp.flags))
		else begin
			errCount++;
			$display("[ERROR] rspData.flags = %h, expected %h (op %0d a %h b %h cin %h)",
				$sampled(rspData.flags), $sampled(expRsp.flags), $sampled(reqData.op),
				$sampled(reqData.a), $sampled(reqData.b), $sampled(reqData.cin));
		end

	// protocol checks
	ackLatency: assert property (@(posedge clk) disable iff (!rstN)
		($past(req, 2) && !$past(req, 3)) |-> ack)
		else begin
			errCount++;
			$display("ack did not rise two edges after req was sampled high");
		end

	ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
		$rose(ack) |-> ($past(req, 2) && !$past(ack, 2)))
		else begin
			errCount++;
			$display("ack rose without a request two edges earlier");
		end

	noSpuriousAck: assert property (@(posedge clk) disable iff (!rstN)
		(!req && !$past(req)) |-> !ack)
		else begin
			errCount++;
			$display("ack is high while req stays low");
		end

	ackDrops: assert property (@(posedge clk) disable iff (!rstN)
		(ack && !req) |=> !ack)
		else begin
			errCount++;
			$display("ack stayed high after req dropped");
		end

	rspHeld: assert property (@(posedge clk) disable iff (!rstN)
		(ack && $past(ack)) |-> $stable(rspData))
		else begin
			errCount++;
			$display("[ERROR] rspData changed to %h while ack high, was %h",
				$sampled(rspData), $past(rspData));
		end

	initial begin : watchdog
		cycleCount = 0;
		while (cycleCount < timeoutCycles) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout after %0d cycles, a handshake never completed", cycleCount);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		rstN        = 1'b0;
		req         = 1'b0;
		reqData     = '0;
		expRsp      = '0;
		seed        = 32'h36423c29;
		errCount    = 0;
		txCount     = 0;
		testsPassed = 0;
		testsFailed = 0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		testHandshake();
		testAdd();
		testSub();
		testCarryIn();
		testEdge();

		$display("tests %0d, passed %0d, failed %0d, transfers %0d, errors %0d",
			testsPassed + testsFailed, testsPassed, testsFailed, txCount, errCount);
		if (errCount == 0 && testsFailed == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
design/arithPkg.sv
design/busPkg.sv
design/PrefixAndOr.sv
design/PrefixAndOrCfast.sv
design/AddSubCore.sv
design/ReqAckPort.sv
design/ArithUnit.sv
test/tbArith.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tbArith
FILELIST  = tb.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

# build, run, then decide by the log
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
